// ==== design/csa_42.sv ====
`timescale 1ns/100ps

module csa_42 #(
    parameter int WI = 8,
    parameter int WO = WI + 2
) (
    input  logic [WI-1:0] a,
    input  logic [WI-1:0] b,
    input  logic [WI-1:0] c,
    input  logic [WI-1:0] d,
    output logic [WO-1:0] sum,
    output logic [WO-1:0] carry
);

    logic [WO-1:0] a_x, b_x, c_x, d_x;
    logic [WO-1:0] row1_s, row1_c;

    // Zero-extend to the output width first
    assign a_x = WO'(a);
    assign b_x = WO'(b);
    assign c_x = WO'(c);
    assign d_x = WO'(d);

    // First full-adder row takes a, b, c
    assign row1_s = a_x ^ b_x ^ c_x;
    assign row1_c = ((a_x & b_x) | (a_x & c_x) | (b_x & c_x)) << 1;

    // Second row folds in d
    assign sum   = row1_s ^ row1_c ^ d_x;
    assign carry = ((row1_s & row1_c) | (row1_s & d_x) | (row1_c & d_x)) << 1;

endmodule

// ==== design/csa_mod4_tree.sv ====
`timescale 1ns/100ps

module csa_mod4_tree (
    input  sum_cfg_pkg::operand_vec_t operands,
    output sum_cfg_pkg::sum_t         sum_vec,
    output sum_cfg_pkg::sum_t         carry_vec
);
    import sum_cfg_pkg::*;

    function automatic int calc_depth(input int n);
        int d;
        int t;
        d = 0;
        t = n;
        while (t > 1) begin
            d = d + 1;
            t = (t + 1) >> 1;
        end
        return d;
    endfunction

    localparam int N_MOD4 = (NUM_OPS >> 2) << 2;
    localparam int N_REM  = NUM_OPS - N_MOD4;
    localparam int NUM_L0 = N_MOD4 >> 2;
    localparam int DEPTH  = calc_depth(NUM_L0);
    localparam int TOTAL_LEVELS = DEPTH + ((N_REM == 3) ? 2 : (N_REM > 0) ? 1 : 0);

    // Two bits of growth per level, capped at the result width
    localparam int MAX_WN = OP_W + TOTAL_LEVELS * 2 + 2;
    localparam int WN     = (SUM_W < MAX_WN) ? SUM_W : MAX_WN;

    function automatic int clamp_w(input int w);
        return (w > WN) ? WN : w;
    endfunction

    // Compressor count at a given tree level
    function automatic int nodes_at(input int lev);
        int n;
        n = NUM_L0;
        for (int k = 0; k < lev; k++) begin
            n = (n + 1) >> 1;
        end
        return n;
    endfunction

    // Inline 3:2 row at full internal width
    function automatic logic [WN-1:0] fa_sum(input logic [WN-1:0] x, y, z);
        return x ^ y ^ z;
    endfunction

    function automatic logic [WN-1:0] fa_carry(input logic [WN-1:0] x, y, z);
        return ((x & y) | (x & z) | (y & z)) << 1;
    endfunction

    logic [WN-1:0] level_s [0:DEPTH][0:NUM_L0-1];
    logic [WN-1:0] level_c [0:DEPTH][0:NUM_L0-1];
    logic [WN-1:0] final_s, final_c;

    // ------------------------------
    // Level 0
    // ------------------------------
    for (genvar i = 0; i < NUM_L0; i++) begin : g_level0
        localparam int WI = clamp_w(OP_W);
        localparam int WO = clamp_w(OP_W + 2);
        logic [WO-1:0] s_out, c_out;

        csa_42 #(.WI(WI), .WO(WO)) u_csa (
            .a     (WI'(operands[i*4 + 0])),
            .b     (WI'(operands[i*4 + 1])),
            .c     (WI'(operands[i*4 + 2])),
            .d     (WI'(operands[i*4 + 3])),
            .sum   (s_out),
            .carry (c_out)
        );

        assign level_s[0][i] = WN'(s_out);
        assign level_c[0][i] = WN'(c_out);
    end

    // ------------------------------
    // Pairwise levels
    // ------------------------------
    for (genvar lev = 1; lev <= DEPTH; lev++) begin : g_levels
        localparam int PREV = nodes_at(lev - 1);
        localparam int CURR = nodes_at(lev);
        localparam int WI   = clamp_w(OP_W + lev * 2);
        localparam int WO   = clamp_w(OP_W + lev * 2 + 2);

        for (genvar i = 0; i < NUM_L0; i++) begin : g_node
            if (i < CURR && (2 * i + 1) < PREV) begin : g_pair
                logic [WO-1:0] s_out, c_out;

                csa_42 #(.WI(WI), .WO(WO)) u_csa (
                    .a     (WI'(level_s[lev-1][2*i])),
                    .b     (WI'(level_c[lev-1][2*i])),
                    .c     (WI'(level_s[lev-1][2*i + 1])),
                    .d     (WI'(level_c[lev-1][2*i + 1])),
                    .sum   (s_out),
                    .carry (c_out)
                );

                assign level_s[lev][i] = WN'(s_out);
                assign level_c[lev][i] = WN'(c_out);
            end else if (i < CURR) begin : g_pass
                // Odd one out goes up unchanged
                assign level_s[lev][i] = level_s[lev-1][2*i];
                assign level_c[lev][i] = level_c[lev-1][2*i];
            end else begin : g_idle
                assign level_s[lev][i] = '0;
                assign level_c[lev][i] = '0;
            end
        end
    end

    // ------------------------------
    // Remainder stage
    // ------------------------------
    if (N_REM == 0) begin : g_rem0
        assign final_s = level_s[DEPTH][0];
        assign final_c = level_c[DEPTH][0];
    end else if (N_REM == 1) begin : g_rem1
        logic [WN-1:0] last_op;

        assign last_op = WN'(operands[NUM_OPS-1]);
        assign final_s = fa_sum(level_s[DEPTH][0], level_c[DEPTH][0], last_op);
        assign final_c = fa_carry(level_s[DEPTH][0], level_c[DEPTH][0], last_op);
    end else if (N_REM == 2) begin : g_rem2
        localparam int WI = clamp_w(OP_W + DEPTH * 2 + 2);
        localparam int WO = clamp_w(OP_W + DEPTH * 2 + 4);
        logic [WO-1:0] s_out, c_out;

        csa_42 #(.WI(WI), .WO(WO)) u_csa (
            .a     (WI'(level_s[DEPTH][0])),
            .b     (WI'(level_c[DEPTH][0])),
            .c     (WI'(operands[NUM_OPS-2])),
            .d     (WI'(operands[NUM_OPS-1])),
            .sum   (s_out),
            .carry (c_out)
        );

        assign final_s = WN'(s_out);
        assign final_c = WN'(c_out);
    end else begin : g_rem3
        logic [WN-1:0] third_op, row_s, row_c;

        // 3:2 row first, then a 4:2 for the last two operands
        assign third_op = WN'(operands[NUM_OPS-3]);
        assign row_s = fa_sum(level_s[DEPTH][0], level_c[DEPTH][0], third_op);
        assign row_c = fa_carry(level_s[DEPTH][0], level_c[DEPTH][0], third_op);

        csa_42 #(.WI(WN), .WO(WN)) u_csa (
            .a     (row_s),
            .b     (row_c),
            .c     (WN'(operands[NUM_OPS-2])),
            .d     (WN'(operands[NUM_OPS-1])),
            .sum   (final_s),
            .carry (final_c)
        );
    end

    assign sum_vec   = SUM_W'(final_s);
    assign carry_vec = SUM_W'(final_c);

endmodule

// ==== design/ks_adder.sv ====
`timescale 1ns/100ps

module ks_adder #(
    parameter int N = 12
) (
    input  logic [N-1:0] a,
    input  logic [N-1:0] b,
    output logic [N-1:0] sum
);

    localparam int LEVELS = $clog2(N);

    // gen[k] and pro[k] cover a span of 2**k bits ending at each position
    logic [N-1:0] gen [0:LEVELS];
    logic [N-1:0] pro [0:LEVELS-1];

    assign gen[0] = a & b;
    assign pro[0] = a ^ b;

    // ------------------------------
    // Prefix levels
    // ------------------------------
    for (genvar k = 0; k < LEVELS; k++) begin : g_level
        localparam int DIST = 1 << k;

        // Zeros shift in from below since carry-in is zero
        assign gen[k+1] = gen[k] | (pro[k] & (gen[k] << DIST));

        // Last level only needs generate
        if (k + 1 < LEVELS) begin : g_pro
            assign pro[k+1] = pro[k] & (pro[k] << DIST);
        end
    end

    // Carry into bit i is the group generate of bits below it
    // and the carry out of the top bit is dropped
    assign sum = pro[0] ^ (gen[LEVELS] << 1);

endmodule

// ==== design/multi_sum_top.sv ====
`timescale 1ns/100ps

module multi_sum_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  sum_op_pkg::sum_op_e       in_op,
    input  sum_cfg_pkg::tag_t         in_tag,
    input  sum_cfg_pkg::operand_vec_t in_operands,
    output logic                      out_valid,
    output sum_cfg_pkg::tag_t         out_tag,
    output sum_cfg_pkg::sum_t         out_sum
);
    import sum_cfg_pkg::*;

    logic         dec_valid;
    tag_t         dec_tag;
    operand_vec_t dec_operands;

    sum_stage_if stage_if ();

    // Decode, execute and result, one cycle each
    sum_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_tag       (in_tag),
        .in_operands  (in_operands),
        .dec_valid    (dec_valid),
        .dec_tag      (dec_tag),
        .dec_operands (dec_operands)
    );

    sum_execute u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec_valid    (dec_valid),
        .dec_tag      (dec_tag),
        .dec_operands (dec_operands),
        .st           (stage_if.producer)
    );

    sum_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .st        (stage_if.consumer),
        .out_valid (out_valid),
        .out_tag   (out_tag),
        .out_sum   (out_sum)
    );

endmodule

// ==== design/sum_cfg_pkg.sv ====
package sum_cfg_pkg;

    // ------------------------------
    // Datapath dimensions
    // ------------------------------

    // Number of operands per command
    localparam int NUM_OPS = 9;

    // Width of one unsigned operand
    localparam int OP_W = 8;

    // Result width, wide enough for the worst-case total
    localparam int SUM_W = OP_W + $clog2(NUM_OPS);

    // Tag that follows each command through the pipe
    localparam int TAG_W = 4;

    typedef logic [NUM_OPS-1:0][OP_W-1:0] operand_vec_t;
    typedef logic [SUM_W-1:0]             sum_t;
    typedef logic [TAG_W-1:0]             tag_t;

endpackage

// ==== design/sum_decode.sv ====
`timescale 1ns/100ps

module sum_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  sum_op_pkg::sum_op_e       in_op,
    input  sum_cfg_pkg::tag_t         in_tag,
    input  sum_cfg_pkg::operand_vec_t in_operands,
    output logic                      dec_valid,
    output sum_cfg_pkg::tag_t         dec_tag,
    output sum_cfg_pkg::operand_vec_t dec_operands
);
    import sum_cfg_pkg::*;
    import sum_op_pkg::*;

    logic [NUM_OPS-1:0] sel_mask;
    operand_vec_t       masked_ops;

    // Unselected operands become zero
    always_comb begin
        sel_mask = op_mask(in_op);
        for (int i = 0; i < NUM_OPS; i++) begin
            masked_ops[i] = sel_mask[i] ? in_operands[i] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    // Payload only moves with a valid command
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec_tag      <= in_tag;
            dec_operands <= masked_ops;
        end
    end

endmodule

// ==== design/sum_execute.sv ====
`timescale 1ns/100ps

module sum_execute (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      dec_valid,
    input  sum_cfg_pkg::tag_t         dec_tag,
    input  sum_cfg_pkg::operand_vec_t dec_operands,
    sum_stage_if.producer             st
);
    import sum_cfg_pkg::*;

    sum_t tree_sum;
    sum_t tree_carry;

    // Reduction tree is purely combinational
    csa_mod4_tree u_tree (
        .operands  (dec_operands),
        .sum_vec   (tree_sum),
        .carry_vec (tree_carry)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st.valid <= 1'b0;
        end else begin
            st.valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            st.tag       <= dec_tag;
            st.sum_vec   <= tree_sum;
            st.carry_vec <= tree_carry;
        end
    end

endmodule

// ==== design/sum_op_pkg.sv ====
package sum_op_pkg;

    typedef enum logic [1:0] {
        SUM_ALL  = 2'd0,
        SUM_EVEN = 2'd1,
        SUM_ODD  = 2'd2,
        SUM_LOW  = 2'd3
    } sum_op_e;

    // Indices 0 to LOW_COUNT-1 form the low group
    localparam int LOW_COUNT = 5;

    // One bit per operand, set when the opcode selects it
    function automatic logic [sum_cfg_pkg::NUM_OPS-1:0] op_mask(input sum_op_e op);
        logic [sum_cfg_pkg::NUM_OPS-1:0] mask;
        for (int i = 0; i < sum_cfg_pkg::NUM_OPS; i++) begin
            case (op)
                SUM_ALL:  mask[i] = 1'b1;
                SUM_EVEN: mask[i] = (i % 2 == 0);
                SUM_ODD:  mask[i] = (i % 2 == 1);
                default:  mask[i] = (i < LOW_COUNT);
            endcase
        end
        return mask;
    endfunction

endpackage

// ==== design/sum_result.sv ====
`timescale 1ns/100ps

module sum_result (
    input  logic              clk,
    input  logic              rst_n,
    sum_stage_if.consumer     st,
    output logic              out_valid,
    output sum_cfg_pkg::tag_t out_tag,
    output sum_cfg_pkg::sum_t out_sum
);
    import sum_cfg_pkg::*;

    sum_t total;

    // Carry-propagate add of the carry-save pair
    ks_adder #(.N(SUM_W)) u_cpa (
        .a   (st.sum_vec),
        .b   (st.carry_vec),
        .sum (total)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= st.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (st.valid) begin
            out_tag <= st.tag;
            out_sum <= total;
        end
    end

endmodule

// ==== design/sum_stage_if.sv ====
`timescale 1ns/100ps

// Carry-save pair handed from execute to result
interface sum_stage_if;
    import sum_cfg_pkg::*;

    logic valid;
    tag_t tag;
    sum_t sum_vec;
    sum_t carry_vec;

    modport producer (
        output valid,
        output tag,
        output sum_vec,
        output carry_vec
    );

    modport consumer (
        input valid,
        input tag,
        input sum_vec,
        input carry_vec
    );

endinterface

// ==== filelist.f ====
design/sum_cfg_pkg.sv
design/sum_op_pkg.sv
design/sum_stage_if.sv
design/csa_42.sv
design/csa_mod4_tree.sv
design/ks_adder.sv
design/sum_decode.sv
design/sum_execute.sv
design/sum_result.sv
design/multi_sum_top.sv
tests/multi_sum_assert.sv
tests/multi_sum_tb.sv

// ==== tests/multi_sum_assert.sv ====
`timescale 1ns/100ps

module multi_sum_assert (
    input logic              clk,
    input logic              rst_n,
    input logic              in_valid,
    input logic              out_valid,
    input sum_cfg_pkg::tag_t out_tag,
    input sum_cfg_pkg::sum_t out_sum
);

    // Reset clears the output strobe and it stays low one more cycle
    property p_reset_clears_valid;
        @(posedge clk) !rst_n |=> !out_valid [*2];
    endproperty

    // Three-cycle latency once the whole pipe has been out of reset
    property p_latency;
        @(posedge clk) ($past(rst_n, 1) && $past(rst_n, 2) && $past(rst_n, 3))
            |-> (out_valid == $past(in_valid, 3));
    endproperty

    property p_result_known;
        @(posedge clk) out_valid |-> !$isunknown({out_tag, out_sum});
    endproperty

    a_reset_clears_valid: assert property (p_reset_clears_valid)
        else $error("out_valid high during or right after reset");
    a_latency: assert property (p_latency)
        else $error("out_valid does not follow in_valid by three cycles");
    a_result_known: assert property (p_result_known)
        else $error("unknown tag or sum while out_valid is high");

endmodule

bind multi_sum_top multi_sum_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_tag   (out_tag),
    .out_sum   (out_sum)
);

// ==== tests/multi_sum_tb.sv ====
`timescale 1ns/100ps

module multi_sum_tb;
    import sum_cfg_pkg::*;
    import sum_op_pkg::*;

    localparam int          CLK_PERIOD  = 40;
    localparam logic [31:0] SEED        = 32'hc1766076;
    localparam int          BURST_LEN   = 50;
    localparam logic [9:0]  GAP_PATTERN = 10'b1011001011;
    localparam int          NUM_CMDS    = 2 + 4 + NUM_OPS + BURST_LEN + 6 + 10;
    localparam int          WATCHDOG_NS = (NUM_CMDS + 20) * CLK_PERIOD;
    // Registered three edges after the drive edge, seen by the monitor one edge later
    localparam int          SEEN_DELAY  = 4;
    localparam int          DRAIN_LIMIT = 10;

    typedef struct packed {
        tag_t        tag;
        sum_t        sum;
        logic [31:0] cycle;
    } exp_item_t;

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    sum_op_e      in_op;
    tag_t         in_tag;
    operand_vec_t in_operands;
    logic         out_valid;
    tag_t         out_tag;
    sum_t         out_sum;

    exp_item_t    exp_q[$];
    exp_item_t    got_item;
    int           errors;
    int           checks;
    logic [31:0]  cycle_cnt;
    logic [31:0]  seed_dummy;

    multi_sum_top multi_sum_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .in_tag      (in_tag),
        .in_operands (in_operands),
        .out_valid   (out_valid),
        .out_tag     (out_tag),
        .out_sum     (out_sum)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
            errors++;
        end
    endtask

    // Reference sum over the operands the opcode selects
    function automatic int expected_sum(input sum_op_e op, input operand_vec_t ops);
        logic [NUM_OPS-1:0] mask;
        int total;
        mask = op_mask(op);
        total = 0;
        for (int i = 0; i < NUM_OPS; i++) begin
            if (mask[i]) total += ops[i];
        end
        return total;
    endfunction

    function automatic operand_vec_t random_ops();
        operand_vec_t ops;
        for (int i = 0; i < NUM_OPS; i++) begin
            ops[i] = OP_W'($urandom_range(0, (1 << OP_W) - 1));
        end
        return ops;
    endfunction

    task automatic send_cmd(input sum_op_e op, input tag_t tag, input operand_vec_t ops);
        exp_item_t item;
        @(posedge clk);
        in_valid    <= 1'b1;
        in_op       <= op;
        in_tag      <= tag;
        in_operands <= ops;
        item.tag   = tag;
        item.sum   = SUM_W'(expected_sum(op, ops));
        item.cycle = cycle_cnt + SEEN_DELAY;
        exp_q.push_back(item);
    endtask

    task automatic drive_idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
    endtask

    // Results are compared in order against the expected queue
    always @(posedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected result with tag %0d arrived at %0t ns with no command pending",
                         out_tag, $time);
                errors++;
            end else begin
                got_item = exp_q.pop_front();
                check_value(out_tag, got_item.tag, "out_tag");
                check_value(out_sum, got_item.sum, "out_sum");
                check_value(cycle_cnt, got_item.cycle, "result cycle");
            end
        end
    end

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_extremes();
        operand_vec_t all_max;
        all_max = '1;
        check_value(expected_sum(SUM_ALL, all_max), 2295, "model sum of nine 255s");
        send_cmd(SUM_ALL, tag_t'(1), all_max);
        send_cmd(SUM_ALL, tag_t'(2), '0);
    endtask

    task automatic test_opcodes();
        operand_vec_t ops;
        // Bit i of each mask selects operand i
        check_value(op_mask(SUM_ALL), 9'b111111111, "SUM_ALL mask");
        check_value(op_mask(SUM_EVEN), 9'b101010101, "SUM_EVEN mask");
        check_value(op_mask(SUM_ODD), 9'b010101010, "SUM_ODD mask");
        check_value(op_mask(SUM_LOW), 9'b000011111, "SUM_LOW mask");
        ops = random_ops();
        send_cmd(SUM_ALL, tag_t'(3), ops);
        send_cmd(SUM_EVEN, tag_t'(4), ops);
        send_cmd(SUM_ODD, tag_t'(5), ops);
        send_cmd(SUM_LOW, tag_t'(6), ops);
    endtask

    // A single 1 walks over every tree input, the leftover one too
    task automatic test_one_hot();
        operand_vec_t ops;
        for (int i = 0; i < NUM_OPS; i++) begin
            ops = '0;
            ops[i] = 1;
            send_cmd(SUM_ALL, tag_t'(i), ops);
        end
    endtask

    task automatic test_burst();
        for (int i = 0; i < BURST_LEN; i++) begin
            send_cmd(sum_op_e'($urandom_range(0, 3)), tag_t'($urandom), random_ops());
        end
    endtask

    task automatic test_gaps();
        for (int i = 9; i >= 0; i--) begin
            if (GAP_PATTERN[i]) send_cmd(SUM_ALL, tag_t'(i), random_ops());
            else drive_idle();
        end
    endtask

    task automatic test_reset_mid_burst();
        for (int i = 0; i < 6; i++) begin
            send_cmd(SUM_ALL, tag_t'($urandom), random_ops());
        end
        @(posedge clk);
        rst_n    <= 1'b0;
        in_valid <= 1'b0;
        // Anything still in flight is lost
        @(posedge clk);
        exp_q.delete();
        @(posedge clk);
        check_value(out_valid, 1'b0, "out_valid during reset");
        rst_n <= 1'b1;
        for (int i = 0; i < 4; i++) begin
            send_cmd(sum_op_e'($urandom_range(0, 3)), tag_t'($urandom), random_ops());
        end
    endtask

    // ------------------------------
    // Main sequence and watchdog
    // ------------------------------
    initial begin
        seed_dummy  = $urandom(SEED);
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_op       = SUM_ALL;
        in_tag      = '0;
        in_operands = '0;
        cycle_cnt   = '0;
        errors      = 0;
        checks      = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_extremes();
        test_opcodes();
        test_one_hot();
        test_burst();
        test_gaps();
        test_reset_mid_burst();
        drive_idle();
        wait_drain();
        if (exp_q.size() != 0) begin
            $display("%0d results are missing at the end of the run", exp_q.size());
            errors += exp_q.size();
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout: the run did not end within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
